/* design/ifu_pkg.sv */
package ifu_pkg;

  // address and instruction width
  localparam int unsigned DATA_W = 32;

  // cache geometry
  localparam int unsigned L1I_LINE_LEN = 1;
  localparam int unsigned L1I_LINE_SIZE = 2 ** L1I_LINE_LEN;
  localparam int unsigned L1I_LEN = 2;
  localparam int unsigned L1I_SIZE = 2 ** L1I_LEN;

  // pc field boundaries
  localparam int unsigned OFF_LSB = 2;
  localparam int unsigned IDX_LSB = OFF_LSB + L1I_LINE_LEN;
  localparam int unsigned TAG_LSB = IDX_LSB + L1I_LEN;
  localparam int unsigned L1I_TAG_W = DATA_W - TAG_LSB;

  localparam logic [DATA_W-1:0] PC_INIT = 32'h8000_0000;

  // opcode classes seen by fetch
  localparam logic [6:0] OP_JAL = 7'b1101111;
  localparam logic [6:0] OP_JALR = 7'b1100111;
  localparam logic [6:0] OP_B_TYPE = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_LOAD = 7'b0000011;
  localparam logic [6:0] OP_STORE = 7'b0100011;

  // fence.i with rd, rs1 and imm all zero
  localparam logic [DATA_W-1:0] INST_FENCE_I = 32'h0000_100f;

  typedef enum logic [2:0] {
    IDLE,
    REQ0,
    GAP,
    REQ1,
    DONE
  } refill_state_t;

endpackage

/* design/l1i_lookup_if.sv */
`timescale 1ns/1ps

interface l1i_lookup_if
  import ifu_pkg::*;
();

  logic [DATA_W-1:0] pc;
  logic              flush;
  logic [DATA_W-1:0] inst;
  logic              hit;
  // no refill in progress
  logic              idle;

  modport ctrl (
    output pc,
    output flush,
    input  inst,
    input  hit,
    input  idle
  );

  modport cache (
    input  pc,
    input  flush,
    output inst,
    output hit,
    output idle
  );

endinterface

/* design/l1i_refill.sv */
`timescale 1ns/1ps

module l1i_refill
  import ifu_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  input  logic              miss_req_i,
  input  logic [DATA_W-1:0] line_addr_i,

  output logic [DATA_W-1:0] ifu_araddr_o,
  output logic              ifu_arvalid_o,
  input  logic [DATA_W-1:0] ifu_rdata_i,
  input  logic              ifu_rvalid_i,

  output logic              wr_en_o,
  output logic              wr_word_o,
  output logic [DATA_W-1:0] wr_data_o,
  output logic              busy_o
);

  refill_state_t     state_q;
  logic [DATA_W-1:0] addr_q;
  logic              in_req;

  assign in_req = (state_q == REQ0) || (state_q == REQ1);

  assign ifu_arvalid_o = in_req;
  // word 0 first, then word 1
  assign ifu_araddr_o = (state_q == REQ1) ? (addr_q | 32'h4) : (addr_q & ~32'h4);

  assign wr_en_o = in_req && ifu_rvalid_i;
  assign wr_word_o = (state_q == REQ1);
  assign wr_data_o = ifu_rdata_i;
  assign busy_o = (state_q != IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (miss_req_i) begin
            state_q <= REQ0;
          end
        end
        REQ0: begin
          if (ifu_rvalid_i) begin
            state_q <= GAP;
          end
        end
        GAP: begin
          state_q <= REQ1;
        end
        REQ1: begin
          if (ifu_rvalid_i) begin
            state_q <= DONE;
          end
        end
        DONE: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // line address captured when the miss is taken
  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && miss_req_i) begin
      addr_q <= line_addr_i;
    end
  end

  // request held with a stable address until the data strobe
  a_arvalid_hold: assert property (
    @(posedge clk) disable iff (rst)
    (ifu_arvalid_o && !ifu_rvalid_i) |=> (ifu_arvalid_o && $stable(ifu_araddr_o))
  );

endmodule

/* design/l1i_cache.sv */
`timescale 1ns/1ps

module l1i_cache
  import ifu_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  l1i_lookup_if.cache       lookup,

  output logic              miss_req_o,
  output logic [DATA_W-1:0] line_addr_o,

  input  logic              wr_en_i,
  input  logic              wr_word_i,
  input  logic [DATA_W-1:0] wr_data_i,
  input  logic              busy_i
);

  logic [DATA_W-1:0]    data_q [L1I_SIZE][L1I_LINE_SIZE];
  logic [L1I_TAG_W-1:0] tag_q [L1I_SIZE];
  logic [L1I_SIZE-1:0]  valid_q;

  logic [L1I_TAG_W-1:0]    pc_tag;
  logic [L1I_LEN-1:0]      pc_idx;
  logic [L1I_LINE_LEN-1:0] pc_off;
  logic                    present;

  // set and tag of the line under refill
  logic [L1I_TAG_W-1:0] fill_tag_q;
  logic [L1I_LEN-1:0]   fill_idx_q;

  assign pc_tag = lookup.pc[DATA_W-1:TAG_LSB];
  assign pc_idx = lookup.pc[TAG_LSB-1:IDX_LSB];
  assign pc_off = lookup.pc[IDX_LSB-1:OFF_LSB];

  assign present = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);

  assign lookup.hit = present && !busy_i;
  assign lookup.inst = data_q[pc_idx][pc_off];
  assign lookup.idle = !busy_i;

  assign miss_req_o = !present && !busy_i;
  assign line_addr_o = {lookup.pc[DATA_W-1:IDX_LSB], {IDX_LSB{1'b0}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (lookup.flush) begin
      valid_q <= '0;
    end else if (wr_en_i && wr_word_i) begin
      // line usable once its last word lands
      valid_q[fill_idx_q] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (miss_req_o) begin
      fill_tag_q <= pc_tag;
      fill_idx_q <= pc_idx;
    end
    if (wr_en_i) begin
      data_q[fill_idx_q][wr_word_i] <= wr_data_i;
      if (wr_word_i) begin
        tag_q[fill_idx_q] <= fill_tag_q;
      end
    end
  end

  // a refill ends only after its last word is written
  a_refill_complete: assert property (
    @(posedge clk) disable iff (rst)
    $fell(busy_i) |-> $past(wr_en_i && wr_word_i, 2)
  );

endmodule

/* design/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl
  import ifu_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  l1i_lookup_if.ctrl        lookup,

  input  logic              prev_valid_i,
  input  logic              next_ready_i,

  input  logic              pc_change_i,
  input  logic [DATA_W-1:0] npc_i,
  input  logic              pc_retire_i,

  output logic [DATA_W-1:0] guess_o,
  output logic [DATA_W-1:0] fall_o,
  output logic              guess_is_b_o,
  output logic              predict_o,

  input  logic              squash_i,
  input  logic              squash_redirected_i,

  output logic              valid_o,
  output logic              ready_o,
  output logic [DATA_W-1:0] inst_o,
  output logic [DATA_W-1:0] pc_o
);

  logic [DATA_W-1:0] pc_q;
  logic              hazard_q;
  logic              guess_pend_q;

  // one-entry branch target buffer
  logic [DATA_W-1:0] btb_q;
  logic              btb_valid_q;

  logic [DATA_W-1:0] guess_q;
  logic [DATA_W-1:0] fall_q;
  logic              guess_is_b_q;

  logic [6:0]        opcode;
  logic              is_branch;
  logic              is_load;
  logic              is_store;
  logic              is_fence;
  logic              accept;
  logic              take_guess;
  logic              report;
  logic              restart;
  logic [DATA_W-1:0] redirect_pc;

  assign opcode = lookup.inst[6:0];
  assign is_branch = (opcode == OP_JAL) || (opcode == OP_JALR) ||
                     (opcode == OP_B_TYPE) || (opcode == OP_SYSTEM);
  assign is_load = (opcode == OP_LOAD);
  assign is_store = (opcode == OP_STORE);
  assign is_fence = (lookup.inst == INST_FENCE_I);

  // memory ops wait until the guess is resolved
  assign valid_o = prev_valid_i && lookup.hit && !hazard_q && !squash_i &&
                   !(guess_pend_q && (is_load || is_store));
  assign ready_o = !valid_o;
  assign accept = valid_o && next_ready_i;

  assign take_guess = accept && is_branch && btb_valid_q && !guess_pend_q;
  assign report = pc_change_i || pc_retire_i;
  assign restart = squash_i && next_ready_i && lookup.idle;
  // btb already holds npc when the restart comes after the report
  assign redirect_pc = pc_change_i ? npc_i : btb_q;

  assign lookup.pc = pc_q;
  assign lookup.flush = accept && is_fence;

  assign inst_o = lookup.inst;
  assign pc_o = pc_q;
  assign predict_o = take_guess;
  assign guess_o = guess_q;
  assign fall_o = fall_q;
  assign guess_is_b_o = guess_is_b_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= PC_INIT;
      hazard_q <= 1'b0;
      guess_pend_q <= 1'b0;
      btb_valid_q <= 1'b0;
    end else begin
      if (pc_change_i) begin
        btb_valid_q <= 1'b1;
      end
      if (report) begin
        guess_pend_q <= 1'b0;
      end

      if (restart) begin
        hazard_q <= 1'b0;
        guess_pend_q <= 1'b0;
        pc_q <= squash_redirected_i ? redirect_pc : fall_q;
      end else if (accept) begin
        if (take_guess) begin
          guess_pend_q <= 1'b1;
          pc_q <= btb_q;
        end else if (is_branch || is_load || is_fence) begin
          hazard_q <= 1'b1;
        end else begin
          pc_q <= pc_q + 32'd4;
        end
      end else if (hazard_q && !guess_pend_q && report) begin
        hazard_q <= 1'b0;
        pc_q <= pc_change_i ? npc_i : pc_q + 32'd4;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pc_change_i) begin
      btb_q <= npc_i;
    end
    if (take_guess) begin
      guess_q <= btb_q;
      fall_q <= pc_q + 32'd4;
      guess_is_b_q <= (opcode == OP_B_TYPE);
    end
  end

  // squash without a restart is still held next cycle
  a_no_valid_in_squash: assert property (
    @(posedge clk) disable iff (rst)
    (squash_i && !(next_ready_i && lookup.idle)) |=> !valid_o
  );

endmodule

/* design/spec_resolve.sv */
`timescale 1ns/1ps

module spec_resolve
  import ifu_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  input  logic              predict_i,
  input  logic [DATA_W-1:0] guess_i,
  input  logic              guess_is_b_i,
  input  logic [DATA_W-1:0] fall_i,

  input  logic              pc_change_i,
  input  logic [DATA_W-1:0] npc_i,
  input  logic              pc_retire_i,
  input  logic [DATA_W-1:0] pc_i,

  input  logic              next_ready_i,
  input  logic              cache_idle_i,

  output logic              squash_o,
  output logic              squash_redirected_o,
  output logic              speculation_o,
  output logic              good_speculation_o,
  output logic              bad_speculation_o
);

  logic              pend_q;
  logic              good_q;
  logic              bad_q;
  logic              redir_q;

  logic              report;
  logic [DATA_W-1:0] retire_npc;
  logic [DATA_W-1:0] real_npc;
  logic              good_now;
  logic              bad_now;
  logic              fall_now;
  logic              restart;

  assign report = pc_change_i || pc_retire_i;
  assign retire_npc = pc_i + 32'd4;
  assign real_npc = pc_change_i ? npc_i : retire_npc;

  assign good_now = pend_q && report && (real_npc == guess_i);
  assign bad_now = pend_q && report && (real_npc != guess_i);
  // not-taken conditional branch, restart on its fall-through
  assign fall_now = guess_is_b_i && pc_retire_i && !pc_change_i && (retire_npc == fall_i);

  assign squash_o = bad_now || bad_q;
  assign squash_redirected_o = bad_now ? !fall_now : redir_q;
  assign restart = squash_o && next_ready_i && cache_idle_i;

  assign speculation_o = pend_q;
  assign good_speculation_o = good_q;
  assign bad_speculation_o = squash_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_q <= 1'b0;
      good_q <= 1'b0;
      bad_q <= 1'b0;
      redir_q <= 1'b0;
    end else begin
      if (predict_i) begin
        pend_q <= 1'b1;
      end else if (report) begin
        pend_q <= 1'b0;
      end
      good_q <= good_now;
      if (restart) begin
        bad_q <= 1'b0;
      end else if (bad_now) begin
        bad_q <= 1'b1;
      end
      if (bad_now) begin
        redir_q <= !fall_now;
      end
    end
  end

  a_good_bad_excl: assert property (
    @(posedge clk) disable iff (rst)
    !(good_speculation_o && bad_speculation_o)
  );

endmodule

/* design/ifu_top.sv */
`timescale 1ns/1ps

module ifu_top
  import ifu_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  output logic [DATA_W-1:0] ifu_araddr_o,
  output logic              ifu_arvalid_o,
  input  logic [DATA_W-1:0] ifu_rdata_i,
  input  logic              ifu_rvalid_i,

  input  logic              prev_valid_i,
  input  logic              next_ready_i,
  output logic              valid_o,
  output logic              ready_o,
  output logic [DATA_W-1:0] inst_o,
  output logic [DATA_W-1:0] pc_o,

  input  logic              pc_change_i,
  input  logic [DATA_W-1:0] npc_i,
  input  logic              pc_retire_i,
  input  logic [DATA_W-1:0] pc_i,

  output logic              speculation_o,
  output logic              good_speculation_o,
  output logic              bad_speculation_o
);

  l1i_lookup_if lookup_if ();

  logic              miss_req;
  logic [DATA_W-1:0] line_addr;
  logic              wr_en;
  logic              wr_word;
  logic [DATA_W-1:0] wr_data;
  logic              refill_busy;

  logic [DATA_W-1:0] guess;
  logic [DATA_W-1:0] fall;
  logic              guess_is_b;
  logic              predict;
  logic              squash;
  logic              squash_redirected;

  l1i_refill u_refill (
    .clk           (clk),
    .rst           (rst),
    .miss_req_i    (miss_req),
    .line_addr_i   (line_addr),
    .ifu_araddr_o  (ifu_araddr_o),
    .ifu_arvalid_o (ifu_arvalid_o),
    .ifu_rdata_i   (ifu_rdata_i),
    .ifu_rvalid_i  (ifu_rvalid_i),
    .wr_en_o       (wr_en),
    .wr_word_o     (wr_word),
    .wr_data_o     (wr_data),
    .busy_o        (refill_busy)
  );

  l1i_cache u_cache (
    .clk         (clk),
    .rst         (rst),
    .lookup      (lookup_if.cache),
    .miss_req_o  (miss_req),
    .line_addr_o (line_addr),
    .wr_en_i     (wr_en),
    .wr_word_i   (wr_word),
    .wr_data_i   (wr_data),
    .busy_i      (refill_busy)
  );

  fetch_ctrl u_ctrl (
    .clk                 (clk),
    .rst                 (rst),
    .lookup              (lookup_if.ctrl),
    .prev_valid_i        (prev_valid_i),
    .next_ready_i        (next_ready_i),
    .pc_change_i         (pc_change_i),
    .npc_i               (npc_i),
    .pc_retire_i         (pc_retire_i),
    .guess_o             (guess),
    .fall_o              (fall),
    .guess_is_b_o        (guess_is_b),
    .predict_o           (predict),
    .squash_i            (squash),
    .squash_redirected_i (squash_redirected),
    .valid_o             (valid_o),
    .ready_o             (ready_o),
    .inst_o              (inst_o),
    .pc_o                (pc_o)
  );

  spec_resolve u_resolve (
    .clk                 (clk),
    .rst                 (rst),
    .predict_i           (predict),
    .guess_i             (guess),
    .guess_is_b_i        (guess_is_b),
    .fall_i              (fall),
    .pc_change_i         (pc_change_i),
    .npc_i               (npc_i),
    .pc_retire_i         (pc_retire_i),
    .pc_i                (pc_i),
    .next_ready_i        (next_ready_i),
    .cache_idle_i        (lookup_if.idle),
    .squash_o            (squash),
    .squash_redirected_o (squash_redirected),
    .speculation_o       (speculation_o),
    .good_speculation_o  (good_speculation_o),
    .bad_speculation_o   (bad_speculation_o)
  );

endmodule

/* test/ifu_mem_model.sv */
`timescale 1ns/1ps

module ifu_mem_model (
  input  logic        clk,
  input  logic        rst,
  input  logic        arvalid_i,
  // image word at the bus address, looked up by the testbench
  input  logic [31:0] word_i,
  output logic [31:0] rdata_o,
  output logic        rvalid_o
);

  int unsigned lcg_state = 21858;
  int          count;
  logic        active;

  // read latency of 1 to 4 cycles
  function automatic int next_latency();
    lcg_state = lcg_state * 1103515245 + 12345;
    return int'((lcg_state >> 16) % 4) + 1;
  endfunction

  initial begin
    rvalid_o = 1'b0;
    rdata_o = '0;
    active = 1'b0;
    count = 0;
    forever begin
      @(negedge clk);
      if (rst) begin
        rvalid_o = 1'b0;
        rdata_o = '0;
        active = 1'b0;
        count = 0;
      end else if (rvalid_o) begin
        rvalid_o = 1'b0;
        active = 1'b0;
      end else if (arvalid_i) begin
        if (!active) begin
          active = 1'b1;
          count = next_latency();
        end
        if (count <= 1) begin
          rvalid_o = 1'b1;
          rdata_o = word_i;
        end else begin
          count = count - 1;
        end
      end
    end
  end

endmodule

/* test/ifu_tb.sv */
`timescale 1ns/1ps

module ifu_tb
  import ifu_pkg::*;
();

  localparam int N_SCRIPTED = 16;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] ifu_araddr_o;
  logic        ifu_arvalid_o;
  logic [31:0] ifu_rdata_i;
  logic        ifu_rvalid_i;
  logic        prev_valid_i;
  logic        next_ready_i;
  logic        valid_o;
  logic        ready_o;
  logic [31:0] inst_o;
  logic [31:0] pc_o;
  logic        pc_change_i;
  logic [31:0] npc_i;
  logic        pc_retire_i;
  logic [31:0] pc_i;
  logic        speculation_o;
  logic        good_speculation_o;
  logic        bad_speculation_o;

  logic [31:0] image [16];
  logic [31:0] exp_pc;
  logic        exp_spec = 1'b0;
  logic        peek = 1'b0;
  logic        stalled = 1'b0;
  logic        quiet = 1'b0;
  logic        expect_good = 1'b0;
  logic        expect_bad = 1'b0;
  logic        need_refill = 1'b0;
  int          reads = 0;
  int          reads_mark = 0;
  logic        arvalid_d = 1'b0;
  logic [31:0] word0_addr = '0;
  int          errors = 0;

  always #2 clk = ~clk;

  ifu_top i_dut (.*);

  ifu_mem_model i_mem (
    .clk       (clk),
    .rst       (rst),
    .arvalid_i (ifu_arvalid_o),
    .word_i    (image[ifu_araddr_o[5:2]]),
    .rdata_o   (ifu_rdata_i),
    .rvalid_o  (ifu_rvalid_i)
  );

  always @(posedge clk) begin
    arvalid_d <= ifu_arvalid_o;
    if (ifu_arvalid_o && !arvalid_d) begin
      reads <= reads + 1;
    end
    if (ifu_arvalid_o && !ifu_araddr_o[2]) begin
      word0_addr <= ifu_araddr_o;
    end
  end

  a_reset: assert property (@(posedge clk) (rst && $past(rst)) |->
    !(valid_o || ifu_arvalid_o || speculation_o || good_speculation_o || bad_speculation_o))
    else begin
      errors++;
      $display("Fail %0t: outputs active in reset", $time);
    end

  // pc, word and speculation state of every accepted or watched fetch
  a_fetch: assert property (@(posedge clk) disable iff (rst)
    (valid_o && (next_ready_i || peek)) |->
    (pc_o == exp_pc && inst_o == image[pc_o[5:2]] && speculation_o == exp_spec))
    else begin
      errors++;
      $display("Fail %0t: fetch pc %h, expected %h", $time, pc_o, exp_pc);
    end

  // fetch takes a new request only while it presents no instruction
  a_ready: assert property (@(posedge clk) disable iff (rst) ready_o == !valid_o)
    else begin
      errors++;
      $display("Fail %0t: ready %b with valid %b", $time, ready_o, valid_o);
    end

  a_stall: assert property (@(posedge clk) disable iff (rst) stalled |-> !valid_o)
    else begin
      errors++;
      $display("Fail %0t: valid during stall", $time);
    end

  a_aligned: assert property (@(posedge clk) disable iff (rst)
    ifu_arvalid_o |-> ifu_araddr_o[1:0] == 2'b00)
    else begin
      errors++;
      $display("Fail %0t: unaligned read %h", $time, ifu_araddr_o);
    end

  a_pair: assert property (@(posedge clk) disable iff (rst)
    ($rose(ifu_arvalid_o) && ifu_araddr_o[2]) |-> ifu_araddr_o == (word0_addr | 32'h4))
    else begin
      errors++;
      $display("Fail %0t: second read %h off line", $time, ifu_araddr_o);
    end

  a_quiet: assert property (@(posedge clk) disable iff (rst) quiet |-> !ifu_arvalid_o)
    else begin
      errors++;
      $display("Fail %0t: bus read on resident line", $time);
    end

  a_good: assert property (@(posedge clk) disable iff (rst)
    ((pc_change_i || pc_retire_i) && expect_good) |=>
    (good_speculation_o && !bad_speculation_o) ##1 !good_speculation_o)
    else begin
      errors++;
      $display("Fail %0t: missing single good pulse", $time);
    end

  a_no_good: assert property (@(posedge clk) disable iff (rst)
    good_speculation_o |-> expect_good)
    else begin
      errors++;
      $display("Fail %0t: unexpected good pulse", $time);
    end

  a_bad: assert property (@(posedge clk) disable iff (rst)
    ((pc_change_i || pc_retire_i) && expect_bad) |-> bad_speculation_o)
    else begin
      errors++;
      $display("Fail %0t: bad speculation not flagged", $time);
    end

  a_no_bad: assert property (@(posedge clk) disable iff (rst)
    bad_speculation_o |-> expect_bad)
    else begin
      errors++;
      $display("Fail %0t: unexpected bad speculation", $time);
    end

  a_refetch: assert property (@(posedge clk) disable iff (rst)
    (valid_o && next_ready_i && need_refill) |-> reads >= reads_mark + 2)
    else begin
      errors++;
      $display("Fail %0t: flushed line not refetched", $time);
    end

  task automatic accept(input logic [31:0] pc);
    exp_pc = pc;
    exp_spec = 1'b0;
    @(negedge clk);
    while (!valid_o) @(negedge clk);
    next_ready_i = 1'b1;
    @(negedge clk);
    next_ready_i = 1'b0;
  endtask

  // watch a fetch without taking it
  task automatic watch(input logic [31:0] pc, input logic spec);
    exp_pc = pc;
    exp_spec = spec;
    peek = 1'b1;
    @(negedge clk);
    while (!valid_o) @(negedge clk);
    @(negedge clk);
    peek = 1'b0;
  endtask

  task automatic report(input logic change, input logic retire, input logic [31:0] npc,
                        input logic [31:0] pc, input logic ready);
    repeat (3) @(negedge clk);
    stalled = 1'b0;
    pc_change_i = change;
    pc_retire_i = retire;
    npc_i = npc;
    pc_i = pc;
    next_ready_i = ready;
    @(negedge clk);
    pc_change_i = 1'b0;
    pc_retire_i = 1'b0;
    next_ready_i = 1'b0;
  endtask

  initial begin
    #(N_SCRIPTED * 40 * 4);
    $display("timeout: fetch did not finish the scripted program");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    image = '{32'h00100093, 32'h00200093, 32'h00300093, 32'h0000a103,
              32'h00400093, 32'h00c0006f, 32'h00600093, 32'h00700093,
              32'h00800093, 32'hfe000ee3, 32'h00a00093, 32'h00b00093,
              32'h00c00093, 32'h00000463, INST_FENCE_I, 32'h00f00093};
    rst = 1'b1;
    prev_valid_i = 1'b0;
    next_ready_i = 1'b0;
    pc_change_i = 1'b0;
    pc_retire_i = 1'b0;
    npc_i = '0;
    pc_i = '0;
    exp_pc = PC_INIT;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    prev_valid_i = 1'b1;

    accept(PC_INIT);
    accept(PC_INIT + 32'h04);
    accept(PC_INIT + 32'h08);
    // load stalls until retired
    accept(PC_INIT + 32'h0c);
    stalled = 1'b1;
    report(1'b0, 1'b1, '0, PC_INIT + 32'h0c, 1'b0);
    accept(PC_INIT + 32'h10);
    // jal without btb entry
    accept(PC_INIT + 32'h14);
    stalled = 1'b1;
    report(1'b1, 1'b0, PC_INIT + 32'h20, '0, 1'b0);
    accept(PC_INIT + 32'h20);
    accept(PC_INIT + 32'h24);

    quiet = 1'b1;
    expect_good = 1'b1;
    watch(PC_INIT + 32'h20, 1'b1);
    report(1'b1, 1'b0, PC_INIT + 32'h20, '0, 1'b0);
    accept(PC_INIT + 32'h20);
    accept(PC_INIT + 32'h24);
    watch(PC_INIT + 32'h20, 1'b1);
    quiet = 1'b0;
    expect_good = 1'b0;

    expect_bad = 1'b1;
    report(1'b1, 1'b0, PC_INIT + 32'h30, '0, 1'b1);
    accept(PC_INIT + 32'h30);
    accept(PC_INIT + 32'h34);
    watch(PC_INIT + 32'h30, 1'b1);
    // not-taken beq resolves to its fall-through
    report(1'b0, 1'b1, '0, PC_INIT + 32'h34, 1'b1);
    accept(PC_INIT + 32'h38);
    expect_bad = 1'b0;
    stalled = 1'b1;
    reads_mark = reads;
    report(1'b0, 1'b1, '0, PC_INIT + 32'h38, 1'b0);
    need_refill = 1'b1;
    accept(PC_INIT + 32'h3c);
    need_refill = 1'b0;

    repeat (4) @(negedge clk);
    $display("run complete, %0d errors", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* ifu_top.f */
design/ifu_pkg.sv
design/l1i_lookup_if.sv
design/l1i_refill.sv
design/l1i_cache.sv
design/fetch_ctrl.sv
design/spec_resolve.sv
design/ifu_top.sv
test/ifu_mem_model.sv
test/ifu_tb.sv

/* Bender.yml */
package:
  name: ifu

sources:
  - design/ifu_pkg.sv
  - design/l1i_lookup_if.sv
  - design/l1i_refill.sv
  - design/l1i_cache.sv
  - design/fetch_ctrl.sv
  - design/spec_resolve.sv
  - design/ifu_top.sv
  - target: test
    files:
      - test/ifu_mem_model.sv
      - test/ifu_tb.sv
